//--- sources.f
+incdir+testbench
design/ex_pkg.sv
design/ex_if.sv
design/ex_regfile.sv
design/ex_issue_reg.sv
design/ex_forward_ctrl.sv
design/ex_operand_mux.sv
design/ex_alu.sv
design/ex_result_pipe.sv
design/ex_top.sv
testbench/tb_ex_top.sv

//--- testbench/tb_ex_model.svh
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// Architectural register state, updated in program order at issue
logic [XLEN-1:0] model_regs [NUM_REGS];
logic [31:0]     lfsr;

task automatic model_reset(input logic [31:0] seed);
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    lfsr = seed;
endtask

// Fibonacci form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);
        v = {v[62:0], lfsr[0]};  // One step per bit
    end
    return v;
endfunction

function automatic logic [XLEN-1:0] ref_exec(input alu_op_e op, input logic word,
        input logic [4:0] rs1, rs2, rd, input logic rd_en, src_pc, src_imm,
        input logic [XLEN-1:0] imm, pc);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    logic [31:0]     a32;
    logic [31:0]     b32;
    logic [31:0]     r32;
    a = src_pc ? pc : model_regs[rs1];
    b = src_imm ? imm : model_regs[rs2];
    a32 = a[31:0];
    b32 = b[31:0];
    if (word) begin
        case (op)
            ADD:     r32 = a32 + b32;
            SUB:     r32 = a32 - b32;
            AND:     r32 = a32 & b32;
            OR:      r32 = a32 | b32;
            XOR:     r32 = a32 ^ b32;
            SLT:     r32 = {31'b0, $signed(a32) < $signed(b32)};
            SLTU:    r32 = {31'b0, a32 < b32};
            SLL:     r32 = a32 << b32[4:0];
            SRL:     r32 = a32 >> b32[4:0];
            SRA:     r32 = $signed(a32) >>> b32[4:0];
            LUI:     r32 = imm[31:0];
            AUIPC:   r32 = pc[31:0] + imm[31:0];
            default: r32 = '0;
        endcase
        r = {{32{r32[31]}}, r32};
    end else begin
        case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SLT:     r = {63'b0, $signed(a) < $signed(b)};
            SLTU:    r = {63'b0, a < b};
            SLL:     r = a << b[5:0];
            SRL:     r = a >> b[5:0];
            SRA:     r = $signed(a) >>> b[5:0];
            LUI:     r = imm;
            AUIPC:   r = pc + imm;
            default: r = '0;
        endcase
    end
    if (rd_en && (rd != 0)) begin
        model_regs[rd] = r;
    end
    return r;
endfunction

`endif

//--- testbench/tb_ex_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ex_top import ex_pkg::*; ();

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 4;
    localparam int NUM_RANDOM     = 300;
    localparam int MAX_GAP        = 3;
    localparam int DIRECTED_SLOTS = 200;  // Upper bound on directed and idle slots
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_SLOTS
                                    + NUM_RANDOM * (1 + MAX_GAP) + 20;

    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] idx;
        logic [XLEN-1:0]      data;
    } exp_t;

    logic                 clk;
    logic                 rst_i;
    logic                 issue_valid_i;
    alu_op_e              alu_op_i;
    logic                 word_i;
    logic [REG_IDX_W-1:0] rs1_index_i;
    logic [REG_IDX_W-1:0] rs2_index_i;
    logic [REG_IDX_W-1:0] rd_index_i;
    logic                 rd_en_i;
    logic                 src_pc_i;
    logic                 src_imm_i;
    logic [XLEN-1:0]      imm_i;
    logic [XLEN-1:0]      pc_i;
    logic                 wb_valid_o;
    logic [REG_IDX_W-1:0] wb_rd_index_o;
    logic [XLEN-1:0]      wb_data_o;

    exp_t            exp_q[$];  // One entry per issue slot, bubbles included
    exp_t            exp_head;
    logic [XLEN-1:0] pc;
    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;

    `include "tb_ex_model.svh"

    ex_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic drive_slot(input logic v, input alu_op_e op, input logic word,
            input logic [4:0] rs1, rs2, rd, input logic rd_en, src_pc, src_imm,
            input logic [XLEN-1:0] imm);
        exp_t e;
        @(posedge clk);
        issue_valid_i <= v;
        alu_op_i      <= op;
        word_i        <= word;
        rs1_index_i   <= rs1;
        rs2_index_i   <= rs2;
        rd_index_i    <= rd;
        rd_en_i       <= rd_en;
        src_pc_i      <= src_pc;
        src_imm_i     <= src_imm;
        imm_i         <= imm;
        pc_i          <= pc;
        e = '0;
        if (v) begin
            e.data  = ref_exec(op, word, rs1, rs2, rd, rd_en, src_pc, src_imm, imm, pc);
            e.valid = rd_en && (rd != 0);
            e.idx   = rd;
            pc = pc + 4;
        end
        exp_q.push_back(e);
    endtask

    task automatic rr(input alu_op_e op, input logic w, input logic [4:0] rd, rs1, rs2);
        drive_slot(1'b1, op, w, rs1, rs2, rd, 1'b1, 1'b0, 1'b0, '0);
    endtask

    task automatic ri(input alu_op_e op, input logic w, input logic [4:0] rd, rs1,
            input logic [XLEN-1:0] imm);
        drive_slot(1'b1, op, w, rs1, 5'd0, rd, 1'b1, 1'b0, 1'b1, imm);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_slot(1'b0, ADD, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic opcode_test();
        logic [5:0] shamts [4];
        shamts = '{6'd0, 6'd31, 6'd32, 6'd63};
        ri(LUI, 1'b0, 5'd1, 5'd0, 64'h8000_0000_0000_0005);
        ri(LUI, 1'b0, 5'd2, 5'd0, 64'h0000_0000_7fff_ffff);
        ri(LUI, 1'b0, 5'd3, 5'd0, 64'hffff_ffff_ffff_fff0);
        ri(LUI, 1'b0, 5'd4, 5'd0, 64'h0123_4567_89ab_cdef);
        for (int w = 0; w < 2; w++) begin
            for (int o = 0; o <= 9; o++) begin
                rr(alu_op_e'(o), w[0], 5'd10, 5'd1, 5'd2);
                rr(alu_op_e'(o), w[0], 5'd11, 5'd3, 5'd1);  // Negative vs negative
                rr(alu_op_e'(o), w[0], 5'd12, 5'd2, 5'd3);
            end
            foreach (shamts[s]) begin
                ri(SLL, w[0], 5'd13, 5'd4, shamts[s]);
                ri(SRL, w[0], 5'd13, 5'd1, shamts[s]);
                ri(SRA, w[0], 5'd13, 5'd1, shamts[s]);
                ri(SRA, w[0], 5'd13, 5'd3, shamts[s]);
            end
            ri(ADD, w[0], 5'd14, 5'd2, 64'd1);  // Crosses the word sign bit
            ri(LUI, w[0], 5'd15, 5'd0, 64'hffff_ffff_8765_4000);
            drive_slot(1'b1, AUIPC, w[0], 5'd0, 5'd0, 5'd16, 1'b1, 1'b1, 1'b1, 64'h7fff_f000);
        end
    endtask

    task automatic forwarding_test();
        for (int d = 1; d <= 3; d++) begin
            ri(ADD, 1'b0, 5'd20, 5'd4, d);
            for (int k = 1; k < d; k++) begin
                ri(XOR, 1'b0, 5'd21, 5'd3, k);
            end
            rr(SUB, 1'b0, 5'd22, 5'd20, 5'd1);  // rs1 at distance d
            rr(AND, 1'b0, 5'd23, 5'd1, 5'd20);  // rs2 at distance d + 1
        end
        rr(ADD, 1'b0, 5'd24, 5'd22, 5'd23);
        rr(XOR, 1'b0, 5'd25, 5'd24, 5'd1);
        rr(SLL, 1'b0, 5'd26, 5'd24, 5'd25);
        // Same rd in both stages
        ri(ADD, 1'b0, 5'd28, 5'd0, 64'd111);
        ri(ADD, 1'b0, 5'd28, 5'd0, 64'd222);
        rr(ADD, 1'b0, 5'd29, 5'd28, 5'd28);
        ri(OR, 1'b0, 5'd28, 5'd0, 64'd333);
        ri(OR, 1'b0, 5'd28, 5'd0, 64'd444);
        idle(1);
        rr(SUB, 1'b0, 5'd29, 5'd28, 5'd0);
    endtask

    task automatic no_write_test();
        ri(ADD, 1'b0, 5'd0, 5'd1, 64'd5);
        rr(ADD, 1'b0, 5'd30, 5'd0, 5'd0);
        drive_slot(1'b1, ADD, 1'b0, 5'd1, 5'd1, 5'd30, 1'b0, 1'b0, 1'b0, '0);
        rr(OR, 1'b0, 5'd31, 5'd30, 5'd0);   // Must not pick up the dropped write
        idle(2);
        rr(ADD, 1'b0, 5'd31, 5'd0, 5'd0);
    endtask

    task automatic random_stream(input int n);
        alu_op_e         op;
        logic [XLEN-1:0] imm;
        for (int i = 0; i < n; i++) begin
            op  = alu_op_e'(rand_bits(4) % 12);
            imm = rand_bits(64);
            if (rand_bits(1)) begin
                imm = {{52{imm[11]}}, imm[11:0]};  // Short immediate
            end
            drive_slot(1'b1, op, rand_bits(1), rand_bits(3), rand_bits(3), rand_bits(3),
                       rand_bits(3) != 0, rand_bits(3) == 0, rand_bits(1), imm);
            if (rand_bits(2) == 0) begin
                idle(rand_bits(2));
            end
        end
    endtask

    initial begin
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        alu_op_i      = ADD;
        word_i        = 1'b0;
        rs1_index_i   = '0;
        rs2_index_i   = '0;
        rd_index_i    = '0;
        rd_en_i       = 1'b0;
        src_pc_i      = 1'b0;
        src_imm_i     = 1'b0;
        imm_i         = '0;
        pc_i          = '0;
        pc            = 64'h8000_0000;
        model_reset(32'd74);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        idle(4);
        for (int r = 1; r < NUM_REGS; r++) begin
            rr(ADD, 1'b0, r, r, 5'd0);  // Every register reads zero after reset
        end
        opcode_test();
        forwarding_test();
        no_write_test();
        random_stream(NUM_RANDOM);
        idle(5);
        @(negedge clk);
        #1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Slot pushed at edge k retires after edge k + 3
    always @(negedge clk) begin
        if (!rst_i) begin
            if (exp_q.size() >= 4) begin
                exp_head = exp_q.pop_front();
                checks++;
                if (wb_valid_o !== exp_head.valid) begin
                    $display("Error at %0t: wb_valid_o expected %b, got %b",
                             $time, exp_head.valid, wb_valid_o);
                    errors++;
                end
                if (exp_head.valid && (wb_rd_index_o !== exp_head.idx)) begin
                    $display("Error at %0t: wb_rd_index_o expected %0d, got %0d",
                             $time, exp_head.idx, wb_rd_index_o);
                    errors++;
                end
                if (exp_head.valid && (wb_data_o !== exp_head.data)) begin
                    $display("Error at %0t: wb_data_o expected %h, got %h",
                             $time, exp_head.data, wb_data_o);
                    errors++;
                end
            end else if (wb_valid_o !== 1'b0) begin
                $display("A writeback showed up at %0t with nothing in flight", $time);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the stimulus never finished", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- design/ex_top.sv
`timescale 1ns/100ps
`default_nettype none

module ex_top import ex_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_i,
    input  wire logic                 issue_valid_i,
    input  wire alu_op_e              alu_op_i,
    input  wire logic                 word_i,
    input  wire logic [REG_IDX_W-1:0] rs1_index_i,
    input  wire logic [REG_IDX_W-1:0] rs2_index_i,
    input  wire logic [REG_IDX_W-1:0] rd_index_i,
    input  wire logic                 rd_en_i,
    input  wire logic                 src_pc_i,
    input  wire logic                 src_imm_i,
    input  wire logic [XLEN-1:0]      imm_i,
    input  wire logic [XLEN-1:0]      pc_i,
    output logic                      wb_valid_o,
    output logic [REG_IDX_W-1:0]      wb_rd_index_o,
    output logic [XLEN-1:0]           wb_data_o
);

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;

    ex_uop_if   uop ();
    ex_stage_if ex2mem (.clk(clk));
    ex_stage_if mem2wb (.clk(clk));
    ex_fwd_if   fwd ();

    ex_issue_reg i_issue_reg (
        .clk           (clk),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .alu_op_i      (alu_op_i),
        .word_i        (word_i),
        .rs1_index_i   (rs1_index_i),
        .rs2_index_i   (rs2_index_i),
        .rd_index_i    (rd_index_i),
        .rd_en_i       (rd_en_i),
        .src_pc_i      (src_pc_i),
        .src_imm_i     (src_imm_i),
        .imm_i         (imm_i),
        .pc_i          (pc_i),
        .uop           (uop.producer)
    );

    ex_regfile i_regfile (
        .clk        (clk),
        .rst_i      (rst_i),
        .uop        (uop.consumer),
        .wb         (mem2wb.consumer),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    ex_forward_ctrl i_forward_ctrl (
        .uop    (uop.consumer),
        .ex2mem (ex2mem.consumer),
        .mem2wb (mem2wb.consumer),
        .fwd    (fwd.producer)
    );

    ex_operand_mux i_operand_mux (
        .uop        (uop.consumer),
        .fwd        (fwd.consumer),
        .ex2mem     (ex2mem.consumer),
        .mem2wb     (mem2wb.consumer),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .op_a_o     (op_a),
        .op_b_o     (op_b)
    );

    ex_alu i_alu (
        .alu_op_i (uop.alu_op),
        .word_i   (uop.word),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .imm_i    (uop.imm),
        .pc_i     (uop.pc),
        .res_o    (alu_res)
    );

    ex_result_pipe i_result_pipe (
        .clk    (clk),
        .rst_i  (rst_i),
        .uop    (uop.consumer),
        .res_i  (alu_res),
        .ex2mem (ex2mem.producer),
        .mem2wb (mem2wb.producer)
    );

    assign wb_valid_o    = mem2wb.valid && mem2wb.rd_en;
    assign wb_rd_index_o = mem2wb.rd_index;
    assign wb_data_o     = mem2wb.data;

endmodule

`default_nettype wire

//--- design/ex_result_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module ex_result_pipe import ex_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_i,
    ex_uop_if.consumer           uop,
    input  wire logic [XLEN-1:0] res_i,
    ex_stage_if.producer         ex2mem,
    ex_stage_if.producer         mem2wb
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex2mem.valid <= 1'b0;
            mem2wb.valid <= 1'b0;
        end else begin
            ex2mem.valid <= uop.valid;
            mem2wb.valid <= ex2mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        // A write to x0 is dropped here, so it never forwards or retires
        ex2mem.rd_en    <= uop.rd_en && (uop.rd_index != '0);
        ex2mem.rd_index <= uop.rd_index;
        ex2mem.data     <= res_i;

        mem2wb.rd_en    <= ex2mem.rd_en;
        mem2wb.rd_index <= ex2mem.rd_index;
        mem2wb.data     <= ex2mem.data;
    end

endmodule

`default_nettype wire

//--- design/ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_alu import ex_pkg::*; (
    input  wire alu_op_e         alu_op_i,
    input  wire logic            word_i,
    input  wire logic [XLEN-1:0] op_a_i,
    input  wire logic [XLEN-1:0] op_b_i,
    input  wire logic [XLEN-1:0] imm_i,
    input  wire logic [XLEN-1:0] pc_i,
    output logic [XLEN-1:0]      res_o
);

    localparam int EXT_W = XLEN - WORD_W;

    logic [XLEN-1:0]    a_ext;
    logic [XLEN-1:0]    b_ext;
    logic [XLEN-1:0]    srl_src;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;
    logic [XLEN-1:0]    raw;

    always_comb begin
        // Word mode narrows the operands to their low half
        if (word_i) begin
            a_ext   = {{EXT_W{op_a_i[WORD_W-1]}}, op_a_i[WORD_W-1:0]};
            b_ext   = {{EXT_W{op_b_i[WORD_W-1]}}, op_b_i[WORD_W-1:0]};
            srl_src = {{EXT_W{1'b0}}, op_a_i[WORD_W-1:0]};  // Logical shift sees zeros above
            shamt   = {1'b0, op_b_i[SHAMT_W-2:0]};
        end else begin
            a_ext   = op_a_i;
            b_ext   = op_b_i;
            srl_src = op_a_i;
            shamt   = op_b_i[SHAMT_W-1:0];
        end
    end

    // Sign-extended narrow values keep their order for both compares
    assign lt_s = $signed(a_ext) < $signed(b_ext);
    assign lt_u = a_ext < b_ext;

    always_comb begin
        case (alu_op_i)
            ADD:     raw = a_ext + b_ext;
            SUB:     raw = a_ext - b_ext;
            AND:     raw = a_ext & b_ext;
            OR:      raw = a_ext | b_ext;
            XOR:     raw = a_ext ^ b_ext;
            SLT:     raw = {{(XLEN-1){1'b0}}, lt_s};
            SLTU:    raw = {{(XLEN-1){1'b0}}, lt_u};
            SLL:     raw = a_ext << shamt;
            SRL:     raw = srl_src >> shamt;
            SRA:     raw = $signed(a_ext) >>> shamt;
            LUI:     raw = imm_i;
            AUIPC:   raw = pc_i + imm_i;
            default: raw = '0;
        endcase
    end

    // Word results are sign-extended from bit 31
    assign res_o = word_i ? {{EXT_W{raw[WORD_W-1]}}, raw[WORD_W-1:0]} : raw;

endmodule

`default_nettype wire

//--- design/ex_operand_mux.sv
`timescale 1ns/100ps
`default_nettype none

module ex_operand_mux import ex_pkg::*; (
    ex_uop_if.consumer       uop,
    ex_fwd_if.consumer       fwd,
    ex_stage_if.consumer     ex2mem,
    ex_stage_if.consumer     mem2wb,
    input  wire logic [XLEN-1:0] rs1_data_i,
    input  wire logic [XLEN-1:0] rs2_data_i,
    output logic [XLEN-1:0]  op_a_o,
    output logic [XLEN-1:0]  op_b_o
);

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    function automatic logic [XLEN-1:0] fwd_value(input src_sel_e sel,
                                                  input logic [XLEN-1:0] rf_val);
        logic [XLEN-1:0] val;
        case (sel)
            SRC_EX2MEM: val = ex2mem.data;
            SRC_MEM2WB: val = mem2wb.data;
            default:    val = rf_val;
        endcase
        return val;
    endfunction

    always_comb begin
        rs1_val = fwd_value(fwd.rs1_sel, rs1_data_i);
        rs2_val = fwd_value(fwd.rs2_sel, rs2_data_i);

        op_a_o = uop.src_pc ? uop.pc : rs1_val;
        op_b_o = uop.src_imm ? uop.imm : rs2_val;
    end

endmodule

`default_nettype wire

//--- design/ex_forward_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ex_forward_ctrl import ex_pkg::*; (
    ex_uop_if.consumer   uop,
    ex_stage_if.consumer ex2mem,
    ex_stage_if.consumer mem2wb,
    ex_fwd_if.producer   fwd
);

    logic ex2mem_live;
    logic mem2wb_live;

    // A stage can only forward if it holds a real register write
    assign ex2mem_live = ex2mem.valid && ex2mem.rd_en;
    assign mem2wb_live = mem2wb.valid && mem2wb.rd_en;

    // Newest producer wins, x0 always comes from the register file
    function automatic src_sel_e pick_src(input logic [REG_IDX_W-1:0] idx);
        src_sel_e sel;
        sel = SRC_RF;
        if (idx != '0) begin
            if (ex2mem_live && (ex2mem.rd_index == idx)) begin
                sel = SRC_EX2MEM;
            end else if (mem2wb_live && (mem2wb.rd_index == idx)) begin
                sel = SRC_MEM2WB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd.rs1_sel = pick_src(uop.rs1_index);
        fwd.rs2_sel = pick_src(uop.rs2_index);
    end

    property p_sel_live(src_sel_e sel);
        @(posedge ex2mem.clk)
        ((sel != SRC_EX2MEM) || ex2mem_live) && ((sel != SRC_MEM2WB) || mem2wb_live);
    endproperty

    a_rs1_sel: assert property (p_sel_live(fwd.rs1_sel))
        else $error("rs1 forwarded from a stage without a write");
    a_rs2_sel: assert property (p_sel_live(fwd.rs2_sel))
        else $error("rs2 forwarded from a stage without a write");

endmodule

`default_nettype wire

//--- design/ex_issue_reg.sv
`timescale 1ns/100ps
`default_nettype none

module ex_issue_reg import ex_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_i,
    input  wire logic                 issue_valid_i,
    input  wire alu_op_e              alu_op_i,
    input  wire logic                 word_i,
    input  wire logic [REG_IDX_W-1:0] rs1_index_i,
    input  wire logic [REG_IDX_W-1:0] rs2_index_i,
    input  wire logic [REG_IDX_W-1:0] rd_index_i,
    input  wire logic                 rd_en_i,
    input  wire logic                 src_pc_i,
    input  wire logic                 src_imm_i,
    input  wire logic [XLEN-1:0]      imm_i,
    input  wire logic [XLEN-1:0]      pc_i,
    ex_uop_if.producer                uop
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            uop.valid <= 1'b0;
        end else begin
            uop.valid <= issue_valid_i;
        end
    end

    // Payload only moves on an issue
    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            uop.alu_op    <= alu_op_i;
            uop.word      <= word_i;
            uop.rs1_index <= rs1_index_i;
            uop.rs2_index <= rs2_index_i;
            uop.rd_index  <= rd_index_i;
            uop.rd_en     <= rd_en_i;
            uop.src_pc    <= src_pc_i;
            uop.src_imm   <= src_imm_i;
            uop.imm       <= imm_i;
            uop.pc        <= pc_i;
        end
    end

    a_legal_op: assert property (@(posedge clk) disable iff (rst_i)
        uop.valid |-> uop.alu_op inside {[ADD:AUIPC]})
        else $error("Illegal ALU opcode in id2ex");

endmodule

`default_nettype wire

//--- design/ex_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module ex_regfile import ex_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_i,
    ex_uop_if.consumer     uop,
    ex_stage_if.consumer   wb,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_en;

    assign wr_en = wb.valid && wb.rd_en && (wb.rd_index != '0);  // x0 is never written

    always_ff @(posedge clk) begin
        if (rst_i) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wb.rd_index] <= wb.data;
        end
    end

    // Reads see the value before a same-cycle write, mem2wb bypass covers it
    assign rs1_data_o = regs[uop.rs1_index];
    assign rs2_data_o = regs[uop.rs2_index];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst_i) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

//--- design/ex_if.sv
`timescale 1ns/100ps
`default_nettype none

// Instruction held in the id2ex register
interface ex_uop_if import ex_pkg::*; ();
    logic                 valid;
    alu_op_e              alu_op;
    logic                 word;
    logic [REG_IDX_W-1:0] rs1_index;
    logic [REG_IDX_W-1:0] rs2_index;
    logic [REG_IDX_W-1:0] rd_index;
    logic                 rd_en;
    logic                 src_pc;   // Operand A from pc
    logic                 src_imm;  // Operand B from imm
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      pc;

    modport producer (output valid, alu_op, word, rs1_index, rs2_index, rd_index,
                      rd_en, src_pc, src_imm, imm, pc);
    modport consumer (input valid, alu_op, word, rs1_index, rs2_index, rd_index,
                      rd_en, src_pc, src_imm, imm, pc);
endinterface

// One result stage, used for ex2mem and mem2wb
interface ex_stage_if import ex_pkg::*; (input logic clk);
    logic                 valid;
    logic                 rd_en;
    logic [REG_IDX_W-1:0] rd_index;
    logic [XLEN-1:0]      data;

    modport producer (output valid, rd_en, rd_index, data);
    modport consumer (input clk, valid, rd_en, rd_index, data);
endinterface

interface ex_fwd_if import ex_pkg::*; ();
    src_sel_e rs1_sel;
    src_sel_e rs2_sel;

    modport producer (output rs1_sel, rs2_sel);
    modport consumer (input rs1_sel, rs2_sel);
endinterface

`default_nettype wire

//--- design/ex_pkg.sv
`default_nettype none

package ex_pkg;

    // Data path and register file geometry
    parameter int XLEN      = 64;
    parameter int WORD_W    = 32;   // Width of the *W instruction forms
    parameter int REG_IDX_W = 5;
    parameter int NUM_REGS  = 32;
    parameter int SHAMT_W   = 6;

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        AND   = 4'd2,
        OR    = 4'd3,
        XOR   = 4'd4,
        SLT   = 4'd5,
        SLTU  = 4'd6,
        SLL   = 4'd7,
        SRL   = 4'd8,
        SRA   = 4'd9,
        LUI   = 4'd10,
        AUIPC = 4'd11
    } alu_op_e;

    // Operand source, one-hot or zero
    typedef enum logic [1:0] {
        SRC_RF     = 2'b00,
        SRC_EX2MEM = 2'b01,
        SRC_MEM2WB = 2'b10
    } src_sel_e;

endpackage

`default_nettype wire
